// File: tb.f
+incdir+hw
hw/timetag_pkg.sv
hw/cmd_parser.sv
hw/strobe_bits_controller.sv
hw/pulse_sequencer.sv
hw/photon_timer.sv
hw/sample_fifo.sv
hw/sample_serializer.sv
hw/timetag.sv
sim/tb_timetag.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert -Wno-fatal -j 0
TOP ?= tb_timetag
FILELIST ?= tb.f
PASS_MSG = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir

// File: sim/tb_timetag.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module tb_timetag import timetag_pkg::*; ();

	typedef enum int {k_seq, k_stop, k_bad_tgt, k_capture, k_cap_off, k_overflow,
		k_clear} kind_t;

	localparam int n_tests = 7;
	localparam int cycle_limit = n_tests * 200;
	localparam int rdy_wait = 50;

	// Name, kind, argument, expected value
	string t_name [n_tests] = '{"seq_rotate", "seq_stop", "bad_target", "capture",
		"capture_off", "overflow", "counter_clear"};
	kind_t t_kind [n_tests] = '{k_seq, k_stop, k_bad_tgt, k_capture, k_cap_off,
		k_overflow, k_clear};
	int t_arg [n_tests] = '{4'b1111, 2, 7, 5, 3, 12, 0};
	int t_exp [n_tests] = '{4'b1111, 4'b1011, 4'b1011, 5, 0, `TT_FIFO_DEPTH + 1, 2};

	logic clk = 1'b0;
	logic arst_n;
	logic cmd_wr;
	cmd_byte_t cmd_in;
	logic data_ack;
	logic [`TT_NUM_CHANNELS-1:0] detectors;
	logic data_rdy;
	cmd_byte_t data;
	logic [`TT_NUM_CHANNELS-1:0] laser_en;
	logic [`TT_NUM_CHANNELS-1:0] pulse_seq_operate;
	logic capture_operate;
	sample_count_t sample_count;

	int seed;
	int cycles = 0;
	int errors;
	int n_pass;
	int n_fail;
	bit test_failed;
	string cur_name = "reset";
	cmd_byte_t pat [`TT_NUM_CHANNELS];

	timetag uut (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_wr(cmd_wr),
		.cmd_in(cmd_in),
		.data_ack(data_ack),
		.detectors(detectors),
		.data_rdy(data_rdy),
		.data(data),
		.laser_en(laser_en),
		.pulse_seq_operate(pulse_seq_operate),
		.capture_operate(capture_operate),
		.sample_count(sample_count)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, test %s did not finish", cycles, cur_name);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [`TT_NUM_CHANNELS-1:0] rand_mask();
		logic [`TT_NUM_CHANNELS-1:0] m;
		m = 4'($random(seed));
		if (m == '0)
			m = 4'b0001;
		return m;
	endfunction

	// True if obs is the pattern rotated right by some amount
	function automatic bit is_rotation(input cmd_byte_t p, input logic [7:0] obs);
		logic [7:0] rot;
		bit found;
		rot = p;
		found = 1'b0;
		for (int r = 0; r < 8; r++)
		begin
			if (obs == rot)
				found = 1'b1;
			rot = {rot[0], rot[7:1]};
		end
		return found;
	endfunction

	task automatic note_error();
		errors++;
		test_failed = 1'b1;
	endtask

	// exp.ts is the lowest allowed timestamp and ts_hi the highest
	task automatic check_sample(input string name, input sample_t exp, input sample_t act,
		input logic [`TT_TS_WIDTH-1:0] ts_hi);
		if ($isunknown(act) || act.lost !== exp.lost || act.lasers !== exp.lasers ||
			act.dets !== exp.dets || act.ts < exp.ts || act.ts > ts_hi)
		begin
			$display("ERR %s expected %h (ts %0d..%0d) actual %h (ts %0d)",
				name, exp, exp.ts, ts_hi, act, act.ts);
			note_error();
		end
	endtask

	task automatic check_count(input string name, input sample_count_t exp,
		input sample_count_t act);
		if (act !== exp)
		begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			note_error();
		end
	endtask

	task automatic check_bits(input string name, input logic [`TT_NUM_CHANNELS-1:0] exp,
		input logic [`TT_NUM_CHANNELS-1:0] act);
		if (act !== exp)
		begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			note_error();
		end
	endtask

	// All host tasks start and end on a falling edge
	task automatic send_cmd(input cmd_byte_t tgt, input cmd_byte_t val);
		cmd_wr = 1'b1;
		cmd_in = tgt;
		@(negedge clk);
		cmd_in = val;
		@(negedge clk);
		cmd_wr = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic pulse_dets(input logic [`TT_NUM_CHANNELS-1:0] m);
		detectors = m;
		@(negedge clk);
		detectors = '0;
		@(negedge clk);
	endtask

	task automatic read_sample(output sample_t s, output bit got);
		int waited;
		waited = 0;
		got = 1'b0;
		s = '0;
		while (!data_rdy && waited < rdy_wait)
		begin
			@(negedge clk);
			waited++;
		end
		if (data_rdy)
		begin
			for (int b = `TT_SAMPLE_BYTES - 1; b >= 0; b--)
			begin
				s[8*b +: 8] = data;
				data_ack = 1'b1;
				@(negedge clk);
				data_ack = 1'b0;
				@(negedge clk);
			end
			got = 1'b1;
		end
	endtask

	// Reads one sample and checks it with the lasers off
	task automatic expect_sample(input string name, input bit lost,
		input logic [`TT_NUM_CHANNELS-1:0] dets, input logic [`TT_TS_WIDTH-1:0] ts_lo,
		input logic [`TT_TS_WIDTH-1:0] ts_hi, output sample_t s);
		sample_t exp;
		bit got;
		exp = '0;
		exp.lost = lost;
		exp.dets = dets;
		exp.ts = ts_lo;
		read_sample(s, got);
		if (!got)
		begin
			$display("%s: data_rdy did not rise within %0d cycles", name, rdy_wait);
			note_error();
		end
		else
			check_sample(name, exp, s, ts_hi);
	endtask

	task automatic run_sequencers(input string name, input int arg, input int exp);
		logic [15:0] hist [`TT_NUM_CHANNELS];
		logic [`TT_NUM_CHANNELS-1:0] ok;
		cmd_byte_t run;
		run = '0;
		for (int i = 0; i < `TT_NUM_CHANNELS; i++)
		begin
			pat[i] = 8'($random(seed));
			send_cmd(8'(`TT_TGT_SEQ0 + i), pat[i]);
			run[2*i] = arg[i];
		end
		send_cmd(8'(`TT_TGT_SEQ_RUN), run);
		check_bits(name, 4'(exp), pulse_seq_operate);
		for (int c = 0; c < 16; c++)
		begin
			@(negedge clk);
			for (int i = 0; i < `TT_NUM_CHANNELS; i++)
				hist[i][c] = laser_en[i];
		end
		for (int i = 0; i < `TT_NUM_CHANNELS; i++)
			ok[i] = (hist[i][7:0] == hist[i][15:8]) && is_rotation(pat[i], hist[i][7:0]);
		check_bits(name, 4'(arg), ok);
	endtask

	task automatic run_stop(input string name, input int arg, input int exp);
		logic [`TT_NUM_CHANNELS-1:0] seen;
		seen = '0;
		send_cmd(8'(`TT_TGT_SEQ_RUN), 8'(1 << (2*arg + 1)));
		check_bits(name, 4'(exp), pulse_seq_operate);
		repeat (16)
		begin
			@(negedge clk);
			seen = seen | laser_en;
		end
		// Stopped lanes must stay dark
		check_bits(name, '0, seen & ~4'(exp));
	endtask

	task automatic run_bad_target(input string name, input int arg, input int exp);
		send_cmd(8'(arg), 8'h55);
		check_bits(name, 4'(exp), pulse_seq_operate);
		check_bits(name, '0, 4'(capture_operate));
	endtask

	task automatic run_capture(input string name, input int arg, input int exp);
		logic [`TT_NUM_CHANNELS-1:0] m;
		logic [`TT_TS_WIDTH-1:0] prev;
		sample_t s;
		prev = '0;
		send_cmd(8'(`TT_TGT_SEQ_RUN), 8'haa);
		send_cmd(8'(`TT_TGT_CAPTURE), 8'h01);
		check_bits(name, 4'b0001, 4'(capture_operate));
		for (int k = 0; k < arg; k++)
		begin
			m = rand_mask();
			pulse_dets(m);
			expect_sample(name, 1'b0, m, prev + 1'b1, '1, s);
			prev = s.ts;
		end
		check_count(name, 16'(exp), sample_count);
	endtask

	task automatic run_capture_off(input string name, input int arg, input int exp);
		sample_count_t count0;
		sample_t s;
		bit got;
		send_cmd(8'(`TT_TGT_CAPTURE), 8'h02);
		check_bits(name, '0, 4'(capture_operate));
		count0 = sample_count;
		for (int k = 0; k < arg; k++)
		begin
			pulse_dets(rand_mask());
			read_sample(s, got);
			if (got)
			begin
				$display("%s: a sample came out while capture was off", name);
				note_error();
			end
		end
		check_count(name, count0 + 16'(exp), sample_count);
	endtask

	task automatic run_overflow(input string name, input int arg, input int exp);
		logic [`TT_NUM_CHANNELS-1:0] masks [$];
		logic [`TT_NUM_CHANNELS-1:0] m;
		logic [`TT_TS_WIDTH-1:0] prev;
		sample_count_t count0;
		sample_t s;
		bit got;
		prev = '0;
		send_cmd(8'(`TT_TGT_CAPTURE), 8'h01);
		count0 = sample_count;
		for (int k = 0; k < arg; k++)
		begin
			m = rand_mask();
			masks.push_back(m);
			pulse_dets(m);
			repeat (2) @(negedge clk);
		end
		// One sample waits in the serializer and the rest fill the FIFO
		for (int k = 0; k < exp; k++)
		begin
			expect_sample(name, 1'b0, masks[k], prev + 1'b1, '1, s);
			prev = s.ts;
		end
		read_sample(s, got);
		if (got)
		begin
			$display("%s: more samples came out than the buffer can hold", name);
			note_error();
		end
		m = rand_mask();
		pulse_dets(m);
		expect_sample(name, 1'b1, m, prev + 1'b1, '1, s);
		check_count(name, count0 + 16'(exp + 1), sample_count);
	endtask

	task automatic run_clear(input string name, input int arg, input int exp);
		logic [`TT_NUM_CHANNELS-1:0] m;
		sample_count_t count0;
		sample_t s1;
		sample_t s2;
		count0 = sample_count;
		m = rand_mask();
		pulse_dets(m);
		expect_sample(name, 1'b0, m, '0, '1, s1);
		send_cmd(8'(`TT_TGT_CAPTURE), 8'h04);
		m = rand_mask();
		pulse_dets(m);
		expect_sample(name, 1'b0, m, '0, s1.ts - 1'b1, s2);
		check_count(name, count0 + 16'(exp), sample_count);
	endtask

	task automatic run_test(input int t);
		case (t_kind[t])
			k_seq: run_sequencers(t_name[t], t_arg[t], t_exp[t]);
			k_stop: run_stop(t_name[t], t_arg[t], t_exp[t]);
			k_bad_tgt: run_bad_target(t_name[t], t_arg[t], t_exp[t]);
			k_capture: run_capture(t_name[t], t_arg[t], t_exp[t]);
			k_cap_off: run_capture_off(t_name[t], t_arg[t], t_exp[t]);
			k_overflow: run_overflow(t_name[t], t_arg[t], t_exp[t]);
			default: run_clear(t_name[t], t_arg[t], t_exp[t]);
		endcase
	endtask

	initial
	begin
		seed = 35;
		errors = 0;
		n_pass = 0;
		n_fail = 0;
		arst_n = 1'b0;
		cmd_wr = 1'b0;
		cmd_in = '0;
		data_ack = 1'b0;
		detectors = '0;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		for (int t = 0; t < n_tests; t++)
		begin
			cur_name = t_name[t];
			test_failed = 1'b0;
			run_test(t);
			if (test_failed)
				n_fail++;
			else
				n_pass++;
			$display("test %0d %s: %s", t, t_name[t], test_failed ? "fail" : "ok");
		end
		$display("%0d tests, %0d ok, %0d failed, %0d errors", n_tests, n_pass, n_fail, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: hw/timetag.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module timetag import timetag_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic cmd_wr,
	input cmd_byte_t cmd_in,
	input logic data_ack,
	input logic [`TT_NUM_CHANNELS-1:0] detectors,
	output logic data_rdy,
	output cmd_byte_t data,
	output logic [`TT_NUM_CHANNELS-1:0] laser_en,
	output logic [`TT_NUM_CHANNELS-1:0] pulse_seq_operate,
	output logic capture_operate,
	output sample_count_t sample_count
);

	target_mask_t cmd_mask;
	target_mask_t tgt_ack;
	cmd_byte_t cmd_data;
	logic cmd_ack;
	logic [7:0] cap_strobes;
	logic [7:0] run_strobes;

	logic sample_rdy;
	sample_t timer_sample;
	sample_t fifo_in;
	sample_t fifo_out;
	logic fifo_wr;
	logic fifo_rd;
	logic fifo_full;
	logic fifo_empty;
	logic samp_lost;

	assign cmd_ack = |tgt_ack;

	cmd_parser u_parser (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_wr(cmd_wr),
		.cmd_in(cmd_in),
		.cmd_ack(cmd_ack),
		.cmd_mask(cmd_mask),
		.cmd_data(cmd_data)
	);

	strobe_bits_controller u_capture_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.mask_bit(cmd_mask[`TT_TGT_CAPTURE]),
		.cmd_data(cmd_data),
		.cmd_ack(tgt_ack[`TT_TGT_CAPTURE]),
		.strobes(cap_strobes)
	);

	strobe_bits_controller u_seq_run_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.mask_bit(cmd_mask[`TT_TGT_SEQ_RUN]),
		.cmd_data(cmd_data),
		.cmd_ack(tgt_ack[`TT_TGT_SEQ_RUN]),
		.strobes(run_strobes)
	);

	// Run latches, clear beats set
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			capture_operate <= 1'b0;
			pulse_seq_operate <= '0;
		end
		else
		begin
			capture_operate <= (capture_operate | cap_strobes[0]) & ~cap_strobes[1];
			for (int i = 0; i < `TT_NUM_CHANNELS; i++)
				pulse_seq_operate[i] <= (pulse_seq_operate[i] | run_strobes[2*i]) &
					~run_strobes[2*i+1];
		end
	end

	for (genvar i = 0; i < `TT_NUM_CHANNELS; i++)
	begin : g_seq
		pulse_sequencer u_seq (
			.clk(clk),
			.arst_n(arst_n),
			.operate(pulse_seq_operate[i]),
			.mask_bit(cmd_mask[`TT_TGT_SEQ0 + i]),
			.cmd_data(cmd_data),
			.cmd_ack(tgt_ack[`TT_TGT_SEQ0 + i]),
			.laser_en(laser_en[i])
		);
	end

	photon_timer u_timer (
		.clk(clk),
		.arst_n(arst_n),
		.operate(capture_operate),
		.reset_counter(cap_strobes[2]),
		.detectors(detectors),
		.lasers(laser_en),
		.sample_rdy(sample_rdy),
		.sample(timer_sample)
	);

	assign fifo_wr = sample_rdy && !fifo_full;

	// Flag a gap in the stream on the next accepted sample
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			samp_lost <= 1'b0;
		else if (sample_rdy && fifo_full)
			samp_lost <= 1'b1;
		else if (fifo_wr)
			samp_lost <= 1'b0;
	end

	always_comb
	begin
		fifo_in = timer_sample;
		fifo_in.lost = samp_lost;
	end

	sample_fifo u_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.wr_en(fifo_wr),
		.wr_data(fifo_in),
		.rd_en(fifo_rd),
		.rd_data(fifo_out),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	sample_serializer u_serializer (
		.clk(clk),
		.arst_n(arst_n),
		.fifo_empty(fifo_empty),
		.fifo_data(fifo_out),
		.data_ack(data_ack),
		.fifo_rd(fifo_rd),
		.data_rdy(data_rdy),
		.data(data)
	);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			sample_count <= '0;
		else if (fifo_wr)
			sample_count <= sample_count + 1'b1;
	end

endmodule

// File: hw/sample_serializer.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module sample_serializer import timetag_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic fifo_empty,
	input sample_t fifo_data,
	input logic data_ack,
	output logic fifo_rd,
	output logic data_rdy,
	output cmd_byte_t data
);

	logic [$bits(sample_t)-1:0] shift_q;
	logic [2:0] byte_idx;
	logic advance;

	// Idle cycle after the last byte comes from data_rdy itself
	assign fifo_rd = !data_rdy && !fifo_empty;
	assign advance = data_rdy && data_ack;
	assign data = shift_q[$bits(sample_t)-1 -: 8];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			data_rdy <= 1'b0;
			byte_idx <= '0;
		end
		else if (fifo_rd)
		begin
			data_rdy <= 1'b1;
			byte_idx <= 3'(`TT_SAMPLE_BYTES - 1);
		end
		else if (advance)
		begin
			if (byte_idx == '0)
				data_rdy <= 1'b0;
			else
				byte_idx <= byte_idx - 1'b1;
		end
	end

	// Top byte first
	always_ff @(posedge clk)
	begin
		if (fifo_rd)
			shift_q <= fifo_data;
		else if (advance)
			shift_q <= shift_q << 8;
	end

endmodule

// File: hw/sample_fifo.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module sample_fifo import timetag_pkg::*;
#(
	parameter int depth = `TT_FIFO_DEPTH
)
(
	input logic clk,
	input logic arst_n,
	input logic wr_en,
	input sample_t wr_data,
	input logic rd_en,
	output sample_t rd_data,
	output logic full,
	output logic empty
);

	localparam int addr_w = $clog2(depth);

	sample_t mem [depth];
	logic [addr_w:0] wr_ptr;
	logic [addr_w:0] rd_ptr;

	// Extra pointer bit tells full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
		(wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

	// Head entry is always visible
	assign rd_data = mem[rd_ptr[addr_w-1:0]];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr[addr_w-1:0]] <= wr_data;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en |-> !full);

	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		rd_en |-> !empty);

endmodule

// File: hw/photon_timer.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module photon_timer import timetag_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic operate,
	input logic reset_counter,
	input logic [`TT_NUM_CHANNELS-1:0] detectors,
	input logic [`TT_NUM_CHANNELS-1:0] lasers,
	output logic sample_rdy,
	output sample_t sample
);

	logic [`TT_TS_WIDTH-1:0] ts;
	logic [`TT_NUM_CHANNELS-1:0] det_q;
	logic [`TT_NUM_CHANNELS-1:0] rose;
	logic hit;

	assign rose = detectors & ~det_q;
	assign hit = operate && (rose != '0);

	// Free running, wraps
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ts <= '0;
		else if (reset_counter)
			ts <= '0;
		else
			ts <= ts + 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			det_q <= '0;
			sample_rdy <= 1'b0;
		end
		else
		begin
			det_q <= detectors;
			sample_rdy <= hit;
		end
	end

	// Lost bit is filled in at the buffer
	always_ff @(posedge clk)
	begin
		if (hit)
		begin
			sample.lost <= 1'b0;
			sample.ts <= ts;
			sample.lasers <= lasers;
			sample.dets <= rose;
		end
	end

endmodule

// File: hw/pulse_sequencer.sv
`timescale 1ns/1ps

module pulse_sequencer import timetag_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic operate,
	input logic mask_bit,
	input cmd_byte_t cmd_data,
	output logic cmd_ack,
	output logic laser_en
);

	logic [7:0] pattern;
	logic load;

	assign load = mask_bit && !cmd_ack;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cmd_ack <= 1'b0;
			laser_en <= 1'b0;
		end
		else
		begin
			cmd_ack <= load;
			laser_en <= operate && pattern[0];
		end
	end

	// Rotate right while running, position held when stopped
	always_ff @(posedge clk)
	begin
		if (load)
			pattern <= cmd_data;
		else if (operate)
			pattern <= {pattern[0], pattern[7:1]};
	end

endmodule

// File: hw/strobe_bits_controller.sv
`timescale 1ns/1ps

module strobe_bits_controller import timetag_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic mask_bit,
	input cmd_byte_t cmd_data,
	output logic cmd_ack,
	output logic [7:0] strobes
);

	logic fire;

	// Fresh command only, the ack masks the held one
	assign fire = mask_bit && !cmd_ack;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cmd_ack <= 1'b0;
			strobes <= '0;
		end
		else
		begin
			cmd_ack <= fire;
			strobes <= fire ? cmd_data : '0;
		end
	end

	a_strobe_single: assert property (@(posedge clk) disable iff (!arst_n)
		(strobes != '0) |=> (strobes == '0));

endmodule

// File: hw/cmd_parser.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module cmd_parser import timetag_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic cmd_wr,
	input cmd_byte_t cmd_in,
	input logic cmd_ack,
	output target_mask_t cmd_mask,
	output cmd_byte_t cmd_data
);

	logic have_tgt;
	cmd_byte_t cmd_tgt;
	target_mask_t tgt_onehot;
	logic take;

	// New bytes only when nothing is pending
	assign take = cmd_wr && (cmd_mask == '0);

	// Out of range targets decode to no bit at all
	always_comb
	begin
		for (int i = 0; i < `TT_NUM_TARGETS; i++)
			tgt_onehot[i] = (cmd_tgt == 8'(i));
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			have_tgt <= 1'b0;
			cmd_mask <= '0;
		end
		else if (take)
		begin
			have_tgt <= !have_tgt;
			if (have_tgt)
				cmd_mask <= tgt_onehot;
		end
		else if (cmd_ack)
			cmd_mask <= '0;
	end

	always_ff @(posedge clk)
	begin
		if (take && !have_tgt)
			cmd_tgt <= cmd_in;
		if (take && have_tgt)
			cmd_data <= cmd_in;
	end

	a_mask_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(cmd_mask));

endmodule

// File: hw/timetag_pkg.sv
`include "timetag_consts.svh"

package timetag_pkg;

	// One byte of the host command stream
	typedef logic [7:0] cmd_byte_t;

	// One bit per command target
	typedef logic [`TT_NUM_TARGETS-1:0] target_mask_t;

	// Sample as sent to the host, top bit first
	typedef struct packed {
		logic lost;
		logic [`TT_TS_WIDTH-1:0] ts;
		logic [`TT_NUM_CHANNELS-1:0] lasers;
		logic [`TT_NUM_CHANNELS-1:0] dets;
	} sample_t;

	// Accepted samples, wraps
	typedef logic [15:0] sample_count_t;

endpackage

// File: hw/timetag_consts.svh
`ifndef TIMETAG_CONSTS_SVH
`define TIMETAG_CONSTS_SVH

// Command targets
`define TT_NUM_TARGETS 6
`define TT_TGT_CAPTURE 0
`define TT_TGT_SEQ_RUN 1
`define TT_TGT_SEQ0 2

// Detector and laser channels
`define TT_NUM_CHANNELS 4

// Timestamp counter width
`define TT_TS_WIDTH 39

// Sample buffer, power of two
`define TT_FIFO_DEPTH 8

// Bytes per sample on the host link
`define TT_SAMPLE_BYTES 6

`endif
